// ==== excTypesPkg.sv ====
package excTypesPkg;

  typedef logic [31:0] pcT;  // Program counter value
  typedef logic [6:0] vectorT;  // One-hot exception vector

  // Bit positions inside vectorT, lowest priority at bit 0
  localparam int VEC_RESET = 0;
  localparam int VEC_UNDEF = 1;
  localparam int VEC_SWI = 2;
  localparam int VEC_PABORT = 3;
  localparam int VEC_DABORT = 4;
  localparam int VEC_IRQ = 5;
  localparam int VEC_FIQ = 6;

  // Offset from PCD that goes into the link register
  typedef enum logic [1:0] {
    PC_PLUS8 = 2'd0,  // Normal flow
    PC_PLUS0 = 2'd1,  // E-stage exceptions and data abort
    PC_PLUS4 = 2'd2   // IRQ and FIQ
  } pcSelT;

  // Byte offset for a PC select code
  function automatic pcT pcOffset(pcSelT sel);
    case (sel)
      PC_PLUS0: pcOffset = 32'd0;
      PC_PLUS4: pcOffset = 32'd4;
      default:  pcOffset = 32'd8;
    endcase
  endfunction

endpackage

// ==== pipeCtrlPkg.sv ====
package pipeCtrlPkg;

  typedef logic [3:0] stageMaskT;  // Flush mask, one bit per stage

  // Stage positions inside stageMaskT
  localparam int MASK_W = 0;
  localparam int MASK_M = 1;
  localparam int MASK_E = 2;
  localparam int MASK_D = 3;

  // Where the pipeline-clear token currently sits
  typedef enum logic [1:0] {
    TOK_IDLE = 2'd0,
    TOK_D = 2'd1,
    TOK_E = 2'd2,
    TOK_M = 2'd3
  } tokenStageT;

endpackage

// ==== pipeFlushIf.sv ====
`timescale 1ns/1ns

// Levels between the exception handler and the clear-token pipe
interface pipeFlushIf;

  logic clearF;  // Insert a clear token at F
  pipeCtrlPkg::stageMaskT flushMask;  // Per-stage flush
  logic stallD;  // Hold the D stage
  logic clearD;  // Token held in D
  logic clearM;  // Token reached M

  modport handler(
    output clearF, flushMask, stallD,
    input clearD, clearM
  );

  modport token(
    input clearF, flushMask, stallD,
    output clearD, clearM
  );

endinterface

// ==== exceptionHandler.sv ====
`timescale 1ns/1ns

module exceptionHandler (
  input  logic clk,
  input  logic rstN,
  input  logic undefInstrE,
  input  logic swiE,
  input  logic prefetchAbortE,
  input  logic dataAbort,
  input  logic irq,
  input  logic fiq,
  input  logic irqEnabled,
  input  logic fiqEnabled,
  pipeFlushIf.handler flushBus,
  output logic undefInstrM,
  output logic swiM,
  output logic prefetchAbortM,
  output logic dataAbortCycle2,
  output logic irqAssert,
  output logic fiqAssert,
  output logic resetMicrop
);

  logic irqEnSync;  // Status bits seen one clock late
  logic fiqEnSync;
  logic fiqReq;
  logic irqReq;
  logic excE;  // Any E-stage exception
  logic clearF;
  logic stallD;
  pipeCtrlPkg::stageMaskT flushMask;

  // Reports move to M, data abort becomes the abort signal for the rest of the core
  always_ff @(posedge clk) begin
    if (!rstN) begin
      undefInstrM <= 1'b0;
      swiM <= 1'b0;
      prefetchAbortM <= 1'b0;
      dataAbortCycle2 <= 1'b0;
    end else begin
      undefInstrM <= undefInstrE;
      swiM <= swiE;
      prefetchAbortM <= prefetchAbortE;
      dataAbortCycle2 <= dataAbort;
    end
  end

  // Status register writes land mid-cycle, so line them up with the edge
  always_ff @(posedge clk) begin
    if (!rstN) begin
      irqEnSync <= 1'b0;
      fiqEnSync <= 1'b0;
    end else begin
      irqEnSync <= irqEnabled;
      fiqEnSync <= fiqEnabled;
    end
  end

  assign excE = undefInstrE | swiE | prefetchAbortE;
  assign fiqReq = fiq & fiqEnSync;
  assign irqReq = irq & irqEnSync;

  // Fixed priority: data abort, E-stage exception, FIQ, IRQ
  always_comb begin
    clearF = 1'b0;
    stallD = 1'b0;
    flushMask = '0;
    irqAssert = 1'b0;
    fiqAssert = 1'b0;
    if (dataAbort || dataAbortCycle2) begin
      // Caught in M, only one of the two is high at a time since M gets flushed
      flushMask[pipeCtrlPkg::MASK_D] = 1'b1;
      flushMask[pipeCtrlPkg::MASK_E] = dataAbort;  // Stall overrides flush of D
      flushMask[pipeCtrlPkg::MASK_M] = 1'b1;
      flushMask[pipeCtrlPkg::MASK_W] = 1'b1;
      stallD = dataAbort;
    end else if (excE) begin
      // Caught in E, last good instruction in M still retires
      flushMask[pipeCtrlPkg::MASK_D] = 1'b1;
      flushMask[pipeCtrlPkg::MASK_M] = 1'b1;
    end else if (fiqReq || irqReq) begin
      // Token walks down while D holds, all older work drains past W
      clearF = ~flushBus.clearM;  // Stop once the token is in M
      flushMask[pipeCtrlPkg::MASK_D] = flushBus.clearD & flushBus.clearM;
      flushMask[pipeCtrlPkg::MASK_E] = flushBus.clearD & ~flushBus.clearM;  // Bubble into E
      stallD = flushBus.clearD & ~flushBus.clearM;
      fiqAssert = fiqReq & flushBus.clearM;
      irqAssert = ~fiqReq & flushBus.clearM;  // FIQ wins
    end
  end

  assign flushBus.clearF = clearF;
  assign flushBus.stallD = stallD;
  assign flushBus.flushMask = flushMask;
  assign resetMicrop = dataAbort;  // Abandon any micro-op sequence

endmodule

// ==== clearTokenPipe.sv ====
`timescale 1ns/1ns

module clearTokenPipe (
  input  logic clk,
  input  logic rstN,
  pipeFlushIf.token flushBus
);

  pipeCtrlPkg::tokenStageT tokState;
  pipeCtrlPkg::tokenStageT tokNext;

  // The D copy of the token stays only while the stall holds it
  always_comb begin
    tokNext = tokState;
    if (flushBus.flushMask[pipeCtrlPkg::MASK_M]) begin
      tokNext = pipeCtrlPkg::TOK_IDLE;  // Abort or E exception kills the token
    end else begin
      case (tokState)
        pipeCtrlPkg::TOK_IDLE: begin
          if (flushBus.clearF) tokNext = pipeCtrlPkg::TOK_D;
        end
        pipeCtrlPkg::TOK_D: begin
          tokNext = flushBus.stallD ? pipeCtrlPkg::TOK_E : pipeCtrlPkg::TOK_IDLE;
        end
        pipeCtrlPkg::TOK_E: begin
          tokNext = flushBus.stallD ? pipeCtrlPkg::TOK_M : pipeCtrlPkg::TOK_IDLE;
        end
        default: tokNext = pipeCtrlPkg::TOK_IDLE;  // One cycle in M, then done
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) tokState <= pipeCtrlPkg::TOK_IDLE;
    else tokState <= tokNext;
  end

  // D keeps its copy until the token has reached M
  assign flushBus.clearD = (tokState != pipeCtrlPkg::TOK_IDLE);
  assign flushBus.clearM = (tokState == pipeCtrlPkg::TOK_M);

endmodule

// ==== vectorUnit.sv ====
`timescale 1ns/1ns

module vectorUnit #(
  parameter excTypesPkg::pcT RESET_PC = 32'h0000_0000
) (
  input  logic clk,
  input  logic rstN,
  input  logic irqAssert,
  input  logic fiqAssert,
  input  logic dataAbortCycle2,
  input  logic prefetchAbortE,
  input  logic swiE,
  input  logic undefInstrE,
  input  excTypesPkg::pcT pcD,
  output excTypesPkg::vectorT pcVector,
  output excTypesPkg::pcSelT pcInSelect,
  output logic savePc,
  output excTypesPkg::pcT linkPc
);

  // One-hot vector, the fetch unit picks the top set bit
  always_comb begin
    pcVector = '0;
    pcVector[excTypesPkg::VEC_FIQ] = fiqAssert;
    pcVector[excTypesPkg::VEC_IRQ] = irqAssert;
    pcVector[excTypesPkg::VEC_DABORT] = dataAbortCycle2;
    pcVector[excTypesPkg::VEC_PABORT] = prefetchAbortE;
    pcVector[excTypesPkg::VEC_SWI] = swiE;
    pcVector[excTypesPkg::VEC_UNDEF] = undefInstrE;
    pcVector[excTypesPkg::VEC_RESET] = ~rstN;
  end

  assign savePc = |pcVector;

  always_comb begin
    if (irqAssert || fiqAssert) begin
      pcInSelect = excTypesPkg::PC_PLUS4;  // Interrupted instruction sits in D
    end else if (prefetchAbortE || swiE || undefInstrE || dataAbortCycle2) begin
      pcInSelect = excTypesPkg::PC_PLUS0;
    end else begin
      pcInSelect = excTypesPkg::PC_PLUS8;
    end
  end

  // Link address, kept until the next exception
  always_ff @(posedge clk) begin
    if (!rstN) begin
      linkPc <= RESET_PC;
    end else if (savePc) begin
      linkPc <= pcD + excTypesPkg::pcOffset(pcInSelect);
    end
  end

endmodule

// ==== excSubsystem.sv ====
`timescale 1ns/1ns

module excSubsystem #(
  parameter excTypesPkg::pcT RESET_PC = 32'h0000_0000
) (
  input  logic clk,
  input  logic rstN,
  input  logic undefInstrE,
  input  logic swiE,
  input  logic prefetchAbortE,
  input  logic dataAbort,
  input  logic irq,
  input  logic fiq,
  input  logic irqEnabled,
  input  logic fiqEnabled,
  input  excTypesPkg::pcT pcD,
  output logic undefInstrM,
  output logic swiM,
  output logic prefetchAbortM,
  output logic dataAbortCycle2,
  output logic irqAssert,
  output logic fiqAssert,
  output logic flushD,
  output logic flushE,
  output logic flushM,
  output logic flushW,
  output logic stallD,
  output logic resetMicrop,
  output logic savePc,
  output excTypesPkg::vectorT pcVector,
  output excTypesPkg::pcSelT pcInSelect,
  output excTypesPkg::pcT linkPc
);

  pipeFlushIf flushBus ();

  exceptionHandler uHandler (
    .clk(clk),
    .rstN(rstN),
    .undefInstrE(undefInstrE),
    .swiE(swiE),
    .prefetchAbortE(prefetchAbortE),
    .dataAbort(dataAbort),
    .irq(irq),
    .fiq(fiq),
    .irqEnabled(irqEnabled),
    .fiqEnabled(fiqEnabled),
    .flushBus(flushBus.handler),
    .undefInstrM(undefInstrM),
    .swiM(swiM),
    .prefetchAbortM(prefetchAbortM),
    .dataAbortCycle2(dataAbortCycle2),
    .irqAssert(irqAssert),
    .fiqAssert(fiqAssert),
    .resetMicrop(resetMicrop)
  );

  clearTokenPipe uTokenPipe (
    .clk(clk),
    .rstN(rstN),
    .flushBus(flushBus.token)
  );

  vectorUnit #(.RESET_PC(RESET_PC)) uVector (
    .clk(clk),
    .rstN(rstN),
    .irqAssert(irqAssert),
    .fiqAssert(fiqAssert),
    .dataAbortCycle2(dataAbortCycle2),
    .prefetchAbortE(prefetchAbortE),
    .swiE(swiE),
    .undefInstrE(undefInstrE),
    .pcD(pcD),
    .pcVector(pcVector),
    .pcInSelect(pcInSelect),
    .savePc(savePc),
    .linkPc(linkPc)
  );

  // Flush mask out to one wire per stage
  assign flushD = flushBus.flushMask[pipeCtrlPkg::MASK_D];
  assign flushE = flushBus.flushMask[pipeCtrlPkg::MASK_E];
  assign flushM = flushBus.flushMask[pipeCtrlPkg::MASK_M];
  assign flushW = flushBus.flushMask[pipeCtrlPkg::MASK_W];
  assign stallD = flushBus.stallD;

endmodule

// ==== tbClock.sv ====
`timescale 1ns/1ns

module tbClock #(
  parameter int PERIOD = 100,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset released with the same small delay as the other stimulus
  initial begin
    rstN = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #10 rstN = 1'b1;
  end

endmodule

// ==== excSubsystem_assertions.sv ====
`timescale 1ns/1ns

// Bound into exceptionHandler, sampled on the rising edge
module excSubsystem_assertions (
  input logic clk,
  input logic rstN,
  input logic dataAbort,
  input logic dataAbortCycle2,
  input logic irqAssert,
  input logic fiqAssert,
  input logic stallD,
  input pipeCtrlPkg::stageMaskT flushMask,
  input logic tokenHeld
);

  int failCount = 0;  // Failed assertions so far

  // One token takes one interrupt
  oneInterruptTaken: assert property (@(posedge clk) disable iff (!rstN)
    !(irqAssert && fiqAssert))
    else begin
      failCount++;
      $error("irqAssert and fiqAssert high in the same cycle");
    end

  // Bubble into E and the D hold only while the abort itself is present
  abortFlushFollows: assert property (@(posedge clk) disable iff (!rstN)
    (dataAbort || dataAbortCycle2) |->
      (flushMask[pipeCtrlPkg::MASK_E] == dataAbort && stallD == dataAbort))
    else begin
      failCount++;
      $error("flushE or stallD does not follow dataAbort during an abort");
    end

  tokenGoneAfterAssert: assert property (@(posedge clk) disable iff (!rstN)
    (irqAssert || fiqAssert) |=> !tokenHeld)
    else begin
      failCount++;
      $error("clear token still present after an interrupt assert");
    end

endmodule

// ==== excChecker.sv ====
`timescale 1ns/1ns

module excChecker #(
  parameter excTypesPkg::pcT RESET_PC = 32'h0000_0000
) (
  input logic clk,
  input logic rstN,
  input logic undefInstrE, swiE, prefetchAbortE, dataAbort,
  input logic irq, fiq, irqEnabled, fiqEnabled,
  input excTypesPkg::pcT pcD,
  input logic undefInstrM, swiM, prefetchAbortM, dataAbortCycle2,
  input logic irqAssert, fiqAssert, resetMicrop, savePc,
  input logic flushD, flushE, flushM, flushW, stallD,
  input excTypesPkg::vectorT pcVector,
  input excTypesPkg::pcSelT pcInSelect,
  input excTypesPkg::pcT linkPc,
  output int errorCount
);

  // Model state as it stands after the last rising edge
  logic [3:0] reportQ = '0;  // {undef, swi, pabort, dabort}
  logic irqEnQ = 1'b0;
  logic fiqEnQ = 1'b0;
  pipeCtrlPkg::tokenStageT tokQ = pipeCtrlPkg::TOK_IDLE;
  excTypesPkg::pcT linkQ = RESET_PC;
  logic armed = 1'b0;  // Nothing to compare before the first edge
  int errors = 0;
  logic abortAny, excE, fiqReq, irqReq, tokHeld, tokInM;
  logic expStall, expClearF, expFiq, expIrq;
  pipeCtrlPkg::stageMaskT expMask;  // {D, E, M, W}
  excTypesPkg::vectorT expVec;
  excTypesPkg::pcSelT expSel;

  assign errorCount = errors;

  function automatic excTypesPkg::pcT offsetFor(excTypesPkg::pcSelT sel);
    if (sel == excTypesPkg::PC_PLUS0) return 32'd0;
    if (sel == excTypesPkg::PC_PLUS4) return 32'd4;
    return 32'd8;
  endfunction

  task automatic checkWord(string name, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  always @(posedge clk) armed <= 1'b1;

  // Mid-cycle compare, inputs settled since shortly after the edge
  always @(negedge clk) begin
    if (armed) begin
      abortAny = dataAbort | reportQ[0];
      excE = undefInstrE | swiE | prefetchAbortE;
      fiqReq = fiq & fiqEnQ;  // Enables count one cycle late
      irqReq = irq & irqEnQ;
      tokHeld = (tokQ != pipeCtrlPkg::TOK_IDLE);
      tokInM = (tokQ == pipeCtrlPkg::TOK_M);
      expMask = '0;
      expStall = 1'b0;
      expClearF = 1'b0;
      expFiq = 1'b0;
      expIrq = 1'b0;
      if (abortAny) begin
        expMask = {1'b1, dataAbort, 2'b11};
        expStall = dataAbort;
      end else if (excE) begin
        expMask = 4'b1010;  // D and M
      end else if (fiqReq || irqReq) begin
        expClearF = !tokInM;
        expStall = tokHeld && !tokInM;
        expMask = {tokInM, expStall, 2'b00};
        expFiq = fiqReq && tokInM;
        expIrq = !fiqReq && tokInM;  // FIQ first
      end
      expVec = {expFiq, expIrq, reportQ[0], prefetchAbortE, swiE, undefInstrE, !rstN};
      expSel = excTypesPkg::PC_PLUS8;
      if (expFiq || expIrq) expSel = excTypesPkg::PC_PLUS4;
      else if (excE || reportQ[0]) expSel = excTypesPkg::PC_PLUS0;

      checkWord("undefInstrM", 32'(reportQ[3]), 32'(undefInstrM));
      checkWord("swiM", 32'(reportQ[2]), 32'(swiM));
      checkWord("prefetchAbortM", 32'(reportQ[1]), 32'(prefetchAbortM));
      checkWord("dataAbortCycle2", 32'(reportQ[0]), 32'(dataAbortCycle2));
      checkWord("irqAssert", 32'(expIrq), 32'(irqAssert));
      checkWord("fiqAssert", 32'(expFiq), 32'(fiqAssert));
      checkWord("flushD", 32'(expMask[3]), 32'(flushD));
      checkWord("flushE", 32'(expMask[2]), 32'(flushE));
      checkWord("flushM", 32'(expMask[1]), 32'(flushM));
      checkWord("flushW", 32'(expMask[0]), 32'(flushW));
      checkWord("stallD", 32'(expStall), 32'(stallD));
      checkWord("resetMicrop", 32'(dataAbort), 32'(resetMicrop));
      checkWord("savePc", 32'(|expVec), 32'(savePc));
      checkWord("pcVector", 32'(expVec), 32'(pcVector));
      checkWord("pcInSelect", 32'(expSel), 32'(pcInSelect));
      checkWord("linkPc", linkQ, linkPc);

      // State for the next edge
      if (!rstN) begin
        reportQ = '0;
        irqEnQ = 1'b0;
        fiqEnQ = 1'b0;
        tokQ = pipeCtrlPkg::TOK_IDLE;
        linkQ = RESET_PC;
      end else begin
        if (|expVec) linkQ = pcD + offsetFor(expSel);
        if (expMask[1]) tokQ = pipeCtrlPkg::TOK_IDLE;  // flushM kills the token
        else if (!tokHeld) tokQ = expClearF ? pipeCtrlPkg::TOK_D : pipeCtrlPkg::TOK_IDLE;
        else if (tokInM || !expStall) tokQ = pipeCtrlPkg::TOK_IDLE;
        else tokQ = (tokQ == pipeCtrlPkg::TOK_D) ? pipeCtrlPkg::TOK_E : pipeCtrlPkg::TOK_M;
        reportQ = {undefInstrE, swiE, prefetchAbortE, dataAbort};
        irqEnQ = irqEnabled;
        fiqEnQ = fiqEnabled;
      end
    end
  end

endmodule

// ==== excTb.sv ====
`timescale 1ns/1ns

module excTb;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_CYCLES = 1500;
  localparam int WATCHDOG_CYCLES = NUM_CYCLES + 500;  // Reset and drain fit easily
  localparam excTypesPkg::pcT RESET_PC = 32'hFFFF_0000;  // High vectors

  logic clk;
  logic rstN;
  logic undefInstrE, swiE, prefetchAbortE, dataAbort;
  logic irq, fiq, irqEnabled, fiqEnabled;
  excTypesPkg::pcT pcD;
  logic undefInstrM, swiM, prefetchAbortM, dataAbortCycle2;
  logic irqAssert, fiqAssert, resetMicrop, savePc;
  logic flushD, flushE, flushM, flushW, stallD;
  excTypesPkg::vectorT pcVector;
  excTypesPkg::pcSelT pcInSelect;
  excTypesPkg::pcT linkPc;
  int errorCount;
  int assertFails;  // Failures seen by the bound assertions
  integer seed = 32'h8d63;
  logic irqSeen;  // Assert seen in the cycle just ended
  logic fiqSeen;

  tbClock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) uClock (.clk(clk), .rstN(rstN));
  excSubsystem #(.RESET_PC(RESET_PC)) u_dut (.*);
  excChecker #(.RESET_PC(RESET_PC)) uChecker (.*);

  bind exceptionHandler excSubsystem_assertions uAssert (
    .clk(clk),
    .rstN(rstN),
    .dataAbort(dataAbort),
    .dataAbortCycle2(dataAbortCycle2),
    .irqAssert(irqAssert),
    .fiqAssert(fiqAssert),
    .stallD(stallD),
    .flushMask(flushMask),
    .tokenHeld(flushBus.clearD)
  );

  // About one cycle in sixteen
  function automatic logic rareEvent();
    return ($random(seed) & 15) == 0;
  endfunction

  task automatic driveCycle();
    undefInstrE = rareEvent();
    swiE = rareEvent();
    prefetchAbortE = rareEvent();
    dataAbort = rareEvent();
    irq = irq ? !irqSeen : rareEvent();  // Held until taken
    fiq = fiq ? !fiqSeen : rareEvent();
    if (($random(seed) & 31) == 0) irqEnabled = !irqEnabled;
    if (($random(seed) & 31) == 0) fiqEnabled = !fiqEnabled;
    pcD = $random(seed) & 32'hFFFF_FFFC;  // Word aligned
  endtask

  initial begin
    undefInstrE = 1'b0;
    swiE = 1'b0;
    prefetchAbortE = 1'b0;
    dataAbort = 1'b0;
    irq = 1'b0;
    fiq = 1'b0;
    irqEnabled = 1'b1;
    fiqEnabled = 1'b1;
    pcD = '0;
    irqSeen = 1'b0;
    fiqSeen = 1'b0;
    assertFails = 0;
    wait (rstN === 1'b1);
    repeat (NUM_CYCLES) begin
      @(negedge clk);
      irqSeen = irqAssert;
      fiqSeen = fiqAssert;
      @(posedge clk);
      #10;
      driveCycle();
    end
    repeat (2) @(negedge clk);  // Last stimulus cycle gets compared
    assertFails = u_dut.uHandler.uAssert.failCount;
    $display("Run of %0d cycles finished with %0d errors and %0d assertion failures",
             NUM_CYCLES, errorCount, assertFails);
    if (errorCount == 0 && assertFails == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired, the run did not end within %0d cycles", WATCHDOG_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== excSubsystem.f ====
excTypesPkg.sv
pipeCtrlPkg.sv
pipeFlushIf.sv
exceptionHandler.sv
clearTokenPipe.sv
vectorUnit.sv
excSubsystem.sv
tbClock.sv
excSubsystem_assertions.sv
excChecker.sv
excTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the exception subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --top-module excTb -Mdir obj_dir -f excSubsystem.f; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VexcTb > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
if grep -q "=== FAIL ===" "$LOG"; then
  exit 1
fi
if ! grep -q "=== PASS ===" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
